// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vec_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass message
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/lane_result_if.sv ====
`timescale 1ns/100ps

interface lane_result_if import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) ();

  // Control comes from lane 0 only
  logic  valid;
  logic  last;
  logic  reduce;

  // One slot per lane
  elem_t partial [NrLanes];

  modport lane (output valid, last, reduce, partial);
  modport res  (input  valid, last, reduce, partial);

endinterface

// ==== hdl/pe_req_if.sv ====
`timescale 1ns/100ps

interface pe_req_if import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) ();

  localparam int unsigned Rows     = VLEN / (ElemWidth * NrLanes);
  localparam int unsigned RowWidth = (Rows > 1) ? $clog2(Rows) : 1;

  // One row step, broadcast to all lanes
  logic                step;
  logic [RowWidth-1:0] row;
  vec_op_e             op;
  vreg_idx_t           vd;
  vreg_idx_t           vs1;
  vreg_idx_t           vs2;
  elem_t               scalar;
  vl_t                 idx;
  vl_t                 vl;
  logic                last;

  modport disp (output step, row, op, vd, vs1, vs2, scalar, idx, vl, last);
  modport lane (input  step, row, op, vd, vs1, vs2, scalar, idx, vl, last);

endinterface

// ==== hdl/vec_dispatcher.sv ====
`timescale 1ns/100ps

module vec_dispatcher import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_op_e   req_op_i,
  input  vreg_idx_t req_vd_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  elem_t     req_scalar_i,
  input  vl_t       req_idx_i,
  input  vl_t       req_vl_i,
  pe_req_if.disp    pe_o
);

  localparam int unsigned Rows     = VLEN / (ElemWidth * NrLanes);
  localparam int unsigned RowWidth = (Rows > 1) ? $clog2(Rows) : 1;

  disp_state_e         state_q;
  logic [RowWidth-1:0] row_q;
  logic                accept;
  logic                last_row;

  // Captured request
  vec_op_e   op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  elem_t     scalar_q;
  vl_t       idx_q;
  vl_t       vl_q;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i & req_ready_o;
  assign last_row    = (row_q == RowWidth'(Rows - 1));

  ////////////////////////////////////////
  // FSM and row counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      row_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= ISSUE;
            row_q   <= '0;
          end
        end
        ISSUE: begin
          row_q <= row_q + 1'b1;
          if (last_row) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= req_op_i;
      vd_q     <= req_vd_i;
      vs1_q    <= req_vs1_i;
      vs2_q    <= req_vs2_i;
      scalar_q <= req_scalar_i;
      idx_q    <= req_idx_i;
      vl_q     <= req_vl_i;
    end
  end

  ////////////////////////////////////////
  // Broadcast
  ////////////////////////////////////////

  assign pe_o.step   = (state_q == ISSUE);
  assign pe_o.row    = row_q;
  assign pe_o.last   = (state_q == ISSUE) & last_row;
  assign pe_o.op     = op_q;
  assign pe_o.vd     = vd_q;
  assign pe_o.vs1    = vs1_q;
  assign pe_o.vs2    = vs2_q;
  assign pe_o.scalar = scalar_q;
  assign pe_o.idx    = idx_q;
  assign pe_o.vl     = vl_q;

endmodule

// ==== hdl/vec_lane.sv ====
`timescale 1ns/100ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256,
  parameter int unsigned LaneId  = 0
) (
  input  logic   clk_i,
  input  logic   rst_i,
  pe_req_if.lane pe_i,
  output elem_t  partial_o,
  output logic   valid_o,
  output logic   last_o,
  output logic   reduce_o
);

  localparam int unsigned Rows = VLEN / (ElemWidth * NrLanes);

  // Register file slice, indexed by register then row
  elem_t vrf_q [NrVRegs][Rows];

  vl_t   elem_idx;
  logic  active;
  logic  idx_hit;
  logic  is_reduce;
  elem_t opnd_vs1;
  elem_t opnd_vs2;
  elem_t alu_res;
  logic  wr_en;
  elem_t partial_d;

  // Element held by this lane in the current row
  assign elem_idx  = vl_t'(pe_i.row) * vl_t'(NrLanes) + vl_t'(LaneId);
  assign active    = (elem_idx < pe_i.vl);
  assign idx_hit   = (elem_idx == pe_i.idx);
  assign is_reduce = (pe_i.op == VREDSUM) | (pe_i.op == VEXT);

  assign opnd_vs1 = vrf_q[pe_i.vs1][pe_i.row];
  assign opnd_vs2 = vrf_q[pe_i.vs2][pe_i.row];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    alu_res   = opnd_vs2;
    wr_en     = 1'b0;
    partial_d = '0;
    case (pe_i.op)
      VINS: begin
        alu_res = pe_i.scalar;
        wr_en   = active & idx_hit;
      end
      VADD_VV: begin
        alu_res = opnd_vs1 + opnd_vs2;
        wr_en   = active;
      end
      VADD_VX: begin
        alu_res = opnd_vs2 + pe_i.scalar;
        wr_en   = active;
      end
      VXOR_VV: begin
        alu_res = opnd_vs1 ^ opnd_vs2;
        wr_en   = active;
      end
      VREDSUM: partial_d = active ? opnd_vs2 : '0;
      // At most one lane contributes
      VEXT:    partial_d = (active && idx_hit) ? opnd_vs2 : '0;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int w = 0; w < Rows; w++) begin
          vrf_q[r][w] <= '0;
        end
      end
    end else if (pe_i.step && wr_en) begin
      vrf_q[pe_i.vd][pe_i.row] <= alu_res;
    end
  end

  // Result toward the result unit, one cycle after the step
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      last_o   <= 1'b0;
      reduce_o <= 1'b0;
    end else begin
      valid_o  <= pe_i.step;
      last_o   <= pe_i.step & pe_i.last;
      reduce_o <= pe_i.step & is_reduce;
    end
  end

  always_ff @(posedge clk_i) begin
    partial_o <= partial_d;
  end

endmodule

// ==== hdl/vec_pkg.sv ====
package vec_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Only 32-bit elements are supported
  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned VlWidth   = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0]       elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Vector length and element index share one width
  typedef logic [VlWidth-1:0] vl_t;

  // Operation encoding
  typedef enum logic [2:0] {
    VINS    = 3'd0,
    VADD_VV = 3'd1,
    VADD_VX = 3'd2,
    VXOR_VV = 3'd3,
    VREDSUM = 3'd4,
    VEXT    = 3'd5
  } vec_op_e;

  // Dispatcher FSM
  typedef enum logic {
    IDLE  = 1'b0,
    ISSUE = 1'b1
  } disp_state_e;

endpackage

// ==== hdl/vec_result_unit.sv ====
`timescale 1ns/100ps

module vec_result_unit import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic          clk_i,
  input  logic          rst_i,
  lane_result_if.res    res_i,
  output logic          resp_valid_o,
  output elem_t         resp_data_o
);

  elem_t acc_q;
  elem_t row_sum;
  elem_t total;
  logic  take;
  logic  finish;

  // Adder tree over the lane slots, wraps modulo 2^32
  always_comb begin
    row_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      row_sum = row_sum + res_i.partial[l];
    end
  end

  assign total  = acc_q + row_sum;
  assign take   = res_i.valid & res_i.reduce;
  assign finish = take & res_i.last;

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q <= '0;
    end else if (take) begin
      if (res_i.last) begin
        acc_q <= '0;
      end else begin
        acc_q <= total;
      end
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  // Single-cycle pulse, host samples without handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= finish;
    end
  end

  always_ff @(posedge clk_i) begin
    if (finish) begin
      resp_data_o <= total;
    end
  end

endmodule

// ==== hdl/vec_top.sv ====
`timescale 1ns/100ps

module vec_top import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic      clk_i,
  input  logic      rst_i,
  // Request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_op_e   req_op_i,
  input  vreg_idx_t req_vd_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  elem_t     req_scalar_i,
  input  vl_t       req_idx_i,
  input  vl_t       req_vl_i,
  // Response
  output logic      resp_valid_o,
  output elem_t     resp_data_o
);

  pe_req_if #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) pe_if ();

  lane_result_if #(
    .NrLanes (NrLanes)
  ) res_if ();

  ////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////

  vec_dispatcher #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) i_dispatcher (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_op_i     (req_op_i    ),
    .req_vd_i     (req_vd_i    ),
    .req_vs1_i    (req_vs1_i   ),
    .req_vs2_i    (req_vs2_i   ),
    .req_scalar_i (req_scalar_i),
    .req_idx_i    (req_idx_i   ),
    .req_vl_i     (req_vl_i    ),
    .pe_o         (pe_if.disp  )
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  // All lanes run in lockstep, lane 0 stands for the rest
  logic [NrLanes-1:0] lane_valid;
  logic [NrLanes-1:0] lane_last;
  logic [NrLanes-1:0] lane_reduce;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes (NrLanes),
      .VLEN    (VLEN   ),
      .LaneId  (l      )
    ) i_lane (
      .clk_i     (clk_i            ),
      .rst_i     (rst_i            ),
      .pe_i      (pe_if.lane       ),
      .partial_o (res_if.partial[l]),
      .valid_o   (lane_valid[l]    ),
      .last_o    (lane_last[l]     ),
      .reduce_o  (lane_reduce[l]   )
    );
  end : gen_lanes

  assign res_if.valid  = lane_valid[0];
  assign res_if.last   = lane_last[0];
  assign res_if.reduce = lane_reduce[0];

  ////////////////////////////////////////
  // Result unit
  ////////////////////////////////////////

  vec_result_unit #(
    .NrLanes (NrLanes)
  ) i_result_unit (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .res_i        (res_if.res  ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o )
  );

endmodule

// ==== sources.f ====
hdl/vec_pkg.sv
hdl/pe_req_if.sv
hdl/lane_result_if.sv
hdl/vec_dispatcher.sv
hdl/vec_lane.sv
hdl/vec_result_unit.sv
hdl/vec_top.sv
tb/vec_assertions.sv
tb/tb_vec_top.sv

// ==== tb/tb_vec_top.sv ====
`timescale 1ns/100ps

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned NrLanes = 4;
  localparam int unsigned VLEN    = 256;
  localparam int unsigned Rows    = VLEN / (ElemWidth * NrLanes);
  localparam int unsigned NrElems = VLEN / ElemWidth;
  // Requests issued over all phases below
  localparam int unsigned NumReqs = 172;

  logic      clk_i;
  logic      rst_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vec_op_e   req_op_i;
  vreg_idx_t req_vd_i;
  vreg_idx_t req_vs1_i;
  vreg_idx_t req_vs2_i;
  elem_t     req_scalar_i;
  vl_t       req_idx_i;
  vl_t       req_vl_i;
  logic      resp_valid_o;
  elem_t     resp_data_o;

  integer      seed;
  int unsigned cycle_cnt = 0;

  // Reference register file indexed by register then element
  elem_t       model_vrf [NrVRegs][NrElems];
  elem_t       exp_data_q [$];
  int unsigned exp_cycle_q [$];

  vec_top #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) uut (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_op_i     (req_op_i    ),
    .req_vd_i     (req_vd_i    ),
    .req_vs1_i    (req_vs1_i   ),
    .req_vs2_i    (req_vs2_i   ),
    .req_scalar_i (req_scalar_i),
    .req_idx_i    (req_idx_i   ),
    .req_vl_i     (req_vl_i    ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // Apply one accepted request to the model and queue any response
  task automatic update_model(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2,
                              elem_t scalar, vl_t idx, vl_t vl, int unsigned resp_cycle);
    elem_t sum;
    sum = '0;
    case (op)
      VINS: begin
        if (idx < vl && idx < NrElems) begin
          model_vrf[vd][idx] = scalar;
        end
      end
      VADD_VV, VADD_VX, VXOR_VV: begin
        for (int e = 0; e < NrElems && e < vl; e++) begin
          if (op == VADD_VV) begin
            model_vrf[vd][e] = model_vrf[vs1][e] + model_vrf[vs2][e];
          end else if (op == VADD_VX) begin
            model_vrf[vd][e] = model_vrf[vs2][e] + scalar;
          end else begin
            model_vrf[vd][e] = model_vrf[vs1][e] ^ model_vrf[vs2][e];
          end
        end
      end
      VREDSUM: begin
        for (int e = 0; e < NrElems && e < vl; e++) begin
          sum = sum + model_vrf[vs2][e];
        end
      end
      VEXT: begin
        if (idx < vl && idx < NrElems) begin
          sum = model_vrf[vs2][idx];
        end
      end
      default: ;
    endcase
    if (op == VREDSUM || op == VEXT) begin
      exp_data_q.push_back(sum);
      exp_cycle_q.push_back(resp_cycle);
    end
  endtask

  // Starts just after a falling edge and returns one falling edge after acceptance
  task automatic send_req(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2,
                          elem_t scalar, vl_t idx, vl_t vl);
    req_op_i     = op;
    req_vd_i     = vd;
    req_vs1_i    = vs1;
    req_vs2_i    = vs2;
    req_scalar_i = scalar;
    req_idx_i    = idx;
    req_vl_i     = vl;
    req_valid_i  = 1'b1;
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    // Response lands in the cycle Rows+2 after the accepting edge
    update_model(op, vd, vs1, vs2, scalar, idx, vl, cycle_cnt + Rows + 1);
  endtask

  task automatic send_random();
    send_req(vec_op_e'(3'(rand_below(6))), vreg_idx_t'(rand_below(8)),
             vreg_idx_t'(rand_below(8)), vreg_idx_t'(rand_below(8)),
             elem_t'($random(seed)), vl_t'(rand_below(10)), vl_t'(rand_below(9)));
  endtask

  task automatic check_response();
    elem_t       exp_data;
    int unsigned exp_cycle;
    if (exp_data_q.size() == 0) begin
      fail_run("Response arrived with no request outstanding");
    end
    exp_data  = exp_data_q.pop_front();
    exp_cycle = exp_cycle_q.pop_front();
    check_value("resp_data_o", resp_data_o, exp_data);
    check_value("resp_valid_o cycle", cycle_cnt, exp_cycle);
  endtask

  always @(negedge clk_i) begin
    if (!rst_i && resp_valid_o) begin
      check_response();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    vreg_idx_t r_sel;
    vl_t       i_sel;
    seed         = 3024;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = VINS;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    req_idx_i    = '0;
    req_vl_i     = '0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < NrElems; e++) begin
        model_vrf[r][e] = '0;
      end
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    check_value("req_ready_o", 32'(req_ready_o), 32'd1);

    // Cleared register file reads back as zero
    for (int r = 0; r < NrVRegs; r++) begin
      send_req(VREDSUM, '0, '0, vreg_idx_t'(r), '0, '0, vl_t'(NrElems));
      send_req(VEXT, '0, '0, vreg_idx_t'(r), '0, vl_t'(rand_below(8)), vl_t'(NrElems));
    end

    // Insert then extract with idx sometimes past vl
    repeat (40) begin
      r_sel = vreg_idx_t'(rand_below(8));
      i_sel = vl_t'(rand_below(10));
      send_req(VINS, r_sel, '0, '0, elem_t'($random(seed)), i_sel, vl_t'(rand_below(9)));
      send_req(VEXT, '0, '0, r_sel, '0, i_sel, vl_t'(rand_below(9)));
    end

    // Mixed traffic with random gaps between requests
    // Gaps of Rows+1 falling edges or more let the DUT drain to idle
    repeat (60) begin
      repeat (rand_below(Rows + 4)) @(negedge clk_i);
      send_random();
    end

    // Reductions at the vl extremes
    for (int r = 0; r < NrVRegs; r++) begin
      send_req(VREDSUM, '0, '0, vreg_idx_t'(r), '0, '0, '0);
      send_req(VREDSUM, '0, '0, vreg_idx_t'(r), '0, '0, vl_t'(NrElems));
    end

    repeat (Rows + 4) @(negedge clk_i);
    if (exp_data_q.size() != 0) begin
      fail_run("Expected responses never arrived");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  // Watchdog
  initial begin
    repeat (NumReqs * (Rows + 3) + 100) @(posedge clk_i);
    fail_run("Timeout, the run did not finish in time");
  end

endmodule

// ==== tb/vec_assertions.sv ====
`timescale 1ns/100ps

module vec_assertions import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input logic clk_i,
  input logic rst_i,
  input logic req_valid_i,
  input logic req_ready_o,
  input logic resp_valid_o
);

  // Response is a single-cycle pulse
  a_resp_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o |=> !resp_valid_o)
    else $error("resp_valid_o high in two consecutive cycles");

  // Dispatcher goes busy right after it takes a request
  a_ready_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_valid_i && req_ready_o) |=> !req_ready_o)
    else $error("req_ready_o still high after an accepted request");

  a_resp_reset: assert property (@(posedge clk_i)
    rst_i |=> !resp_valid_o)
    else $error("resp_valid_o high during reset");

  ////////////////////////////////////////
  // Parameter sanity, once after reset
  ////////////////////////////////////////

  a_lanes_pow2: assert property (@(posedge clk_i)
    $fell(rst_i) |-> ((NrLanes & (NrLanes - 1)) == 0))
    else $error("NrLanes is not a power of two");

  a_vlen_min: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (VLEN >= ElemWidth * NrLanes))
    else $error("VLEN too small for one row across all lanes");

endmodule

bind vec_top vec_assertions #(
  .NrLanes (NrLanes),
  .VLEN    (VLEN   )
) i_assertions (
  .clk_i        (clk_i       ),
  .rst_i        (rst_i       ),
  .req_valid_i  (req_valid_i ),
  .req_ready_o  (req_ready_o ),
  .resp_valid_o (resp_valid_o)
);
